//--- verilog/fir_pkg.sv
// shared widths, types and coefficients of the serial Morse FIR filter
// modules refer to these by scoped names, nothing is imported

package fir_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int SAMPLE_W    = 10;
	localparam int COEFF_W     = 17;
	localparam int ACC_W       = 32;
	localparam int NUM_TAPS    = 32;
	localparam int SCALE_SHIFT = 15;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEFF_W-1:0]  coeff_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

	// new sample from the receiver, or a sample moving into the next lane
	typedef struct packed {
		logic    valid;
		sample_t data;
	} sample_s;

	// finished partial sum of one lane, held until the transmitter takes it
	typedef struct packed {
		logic ready;
		acc_t sum;
	} lane_result_s;

	////////////////////////////////////////////////////////////////////////////
	// coefficients
	////////////////////////////////////////////////////////////////////////////

	// age 0 is the newest sample, the big centre tap sits at age 15
	function automatic coeff_t coeff_at(input int unsigned age);
		case (age)
			0:  return 17'sd962;
			1:  return 17'sd795;
			2:  return 17'sd314;
			3:  return -17'sd301;
			4:  return -17'sd813;
			5:  return -17'sd1021;
			6:  return -17'sd837;
			7:  return -17'sd326;
			8:  return 17'sd318;
			9:  return 17'sd848;
			10: return 17'sd1057;
			11: return 17'sd861;
			12: return 17'sd331;
			13: return -17'sd329;
			14: return -17'sd865;
			15: return 17'sd31698;
			16: return -17'sd865;
			17: return -17'sd329;
			18: return 17'sd331;
			19: return 17'sd861;
			20: return 17'sd1057;
			21: return 17'sd848;
			22: return 17'sd318;
			23: return -17'sd326;
			24: return -17'sd837;
			25: return -17'sd1021;
			26: return -17'sd813;
			27: return -17'sd301;
			28: return 17'sd314;
			29: return 17'sd795;
			30: return 17'sd962;
			31: return 17'sd761;
			// ages past the table contribute nothing
			default: return '0;
		endcase
	endfunction

endpackage

//--- verilog/serial_sample_rx.sv
// bit-serial sample receiver, MSB first, one bit per clock while hndshk is high
// issues the finished sample with a one-cycle valid strobe

module serial_sample_rx
(
	input  logic              clk,
	input  logic              reset,
	input  logic              hndshk,
	input  logic              data_in,
	output fir_pkg::sample_s  new_sample
);

	localparam int CNT_W = $clog2(fir_pkg::SAMPLE_W);

	logic [CNT_W-1:0]              bit_cnt;
	logic [fir_pkg::SAMPLE_W-2:0]  shreg;
	logic                          sample_valid;
	fir_pkg::sample_t              sample_data;
	logic                          last_bit;

	// tenth bit of the current sample is on data_in
	assign last_bit = hndshk && (bit_cnt == CNT_W'(fir_pkg::SAMPLE_W - 1));

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_cnt      <= '0;
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= last_bit;
			if (last_bit)
				bit_cnt <= '0;
			else if (hndshk)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// shift path, only the counter decides when the word is complete
	always_ff @(posedge clk)
	begin
		if (hndshk)
			shreg <= {shreg[fir_pkg::SAMPLE_W-3:0], data_in};
		if (last_bit)
			sample_data <= {shreg, data_in};
	end

	assign new_sample = '{valid: sample_valid, data: sample_data};

endmodule

//--- verilog/fir_lane.sv
// one segment of the FIR delay line with its own sequential multiply-accumulate
// lanes are chained, each one passes its oldest sample to the next

module fir_lane
#(
	parameter int TAPS_PER_LANE = 8,
	parameter int LANE_INDEX    = 0
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  hndshk,
	input  fir_pkg::sample_s      sample_in,
	output fir_pkg::sample_s      shift_out,
	input  logic                  result_taken,
	output fir_pkg::lane_result_s result
);

	localparam int IDX_W = (TAPS_PER_LANE > 1) ? $clog2(TAPS_PER_LANE) : 1;

	fir_pkg::sample_t  taps [TAPS_PER_LANE];
	fir_pkg::sample_t  operand;
	fir_pkg::coeff_t   coeff;
	fir_pkg::acc_t     product;
	fir_pkg::acc_t     acc;
	logic [IDX_W-1:0]  tap_idx;
	logic [IDX_W-1:0]  idx_eff;
	int unsigned       tap_age;
	logic              busy;
	logic              ready;
	logic              mac_en;
	logic              last_tap;

	// oldest entry leaves on the same strobe that shifts this segment
	assign shift_out = '{valid: sample_in.valid, data: taps[TAPS_PER_LANE-1]};

	////////////////////////////////////////////////////////////////////////////
	// delay line segment
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < TAPS_PER_LANE; i++)
				taps[i] <= '0;
		end
		else if (sample_in.valid)
		begin
			taps[0] <= sample_in.data;
			for (int i = 1; i < TAPS_PER_LANE; i++)
				taps[i] <= taps[i-1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// multiply-accumulate
	////////////////////////////////////////////////////////////////////////////

	// the shift cycle already takes its first product from the incoming sample
	always_comb
	begin
		if (sample_in.valid)
		begin
			idx_eff = '0;
			operand = sample_in.data;
		end
		else
		begin
			idx_eff = tap_idx;
			operand = taps[tap_idx];
		end
		tap_age = LANE_INDEX * TAPS_PER_LANE + int'(idx_eff);
		coeff   = fir_pkg::coeff_at(tap_age);
		product = fir_pkg::acc_t'(operand) * fir_pkg::acc_t'(coeff);
	end

	assign mac_en   = (busy || sample_in.valid) && !hndshk;
	assign last_tap = (idx_eff == IDX_W'(TAPS_PER_LANE - 1));

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			busy    <= 1'b0;
			ready   <= 1'b0;
			tap_idx <= '0;
		end
		else if (result_taken)
			ready <= 1'b0;
		else if (mac_en)
		begin
			busy    <= !last_tap;
			ready   <= last_tap;
			tap_idx <= last_tap ? '0 : idx_eff + 1'b1;
		end
		else if (sample_in.valid)
		begin
			// host still holds hndshk high, wait for the low phase
			busy    <= 1'b1;
			tap_idx <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (result_taken)
			acc <= '0;
		else if (mac_en)
			acc <= (sample_in.valid ? '0 : acc) + product;
		else if (sample_in.valid)
			acc <= '0;
	end

	assign result = '{ready: ready, sum: acc};

endmodule

//--- verilog/result_tx.sv
// adds the lane sums, scales them and returns the 32-bit word LSB first
// every returned bit is marked by a toggle of clk_out

module result_tx
#(
	parameter int NUM_LANES = 4
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  fir_pkg::lane_result_s lane_results [NUM_LANES],
	output logic                  result_taken,
	output logic                  data_out,
	output logic                  clk_out
);

	localparam int CNT_W = $clog2(fir_pkg::ACC_W);

	typedef enum logic [1:0] {
		IDLE,
		SCALE,
		SEND
	} tx_state_e;

	tx_state_e          state;
	logic [CNT_W-1:0]   bit_cnt;
	fir_pkg::acc_t      lane_sum;
	fir_pkg::acc_t      scaled;
	fir_pkg::acc_t      shreg;
	logic               all_ready;
	logic               last_bit;

	always_comb
	begin
		all_ready = 1'b1;
		lane_sum  = '0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			all_ready = all_ready & lane_results[i].ready;
			lane_sum  = lane_sum + lane_results[i].sum;
		end
	end

	assign scaled = lane_sum >>> fir_pkg::SCALE_SHIFT;

	// lanes drop ready on the edge that sends the 32nd bit
	assign last_bit     = (bit_cnt == CNT_W'(fir_pkg::ACC_W - 1));
	assign result_taken = (state == SEND) && last_bit;

	////////////////////////////////////////////////////////////////////////////
	// FSM and serial output
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state    <= IDLE;
			bit_cnt  <= '0;
			data_out <= 1'b0;
			clk_out  <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (all_ready)
						state <= SCALE;
				SCALE:
				begin
					// scaled word goes straight out, bit 0 first
					data_out <= scaled[0];
					clk_out  <= ~clk_out;
					bit_cnt  <= CNT_W'(1);
					state    <= SEND;
				end
				SEND:
				begin
					data_out <= shreg[0];
					clk_out  <= ~clk_out;
					bit_cnt  <= bit_cnt + 1'b1;
					if (last_bit)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == SCALE)
			shreg <= scaled >>> 1;
		else if (state == SEND)
			shreg <= shreg >>> 1;
	end

endmodule

//--- verilog/morse_fir_top.sv
// serial-in, serial-out FIR filter for a Morse signal with an interfering sine
// receiver feeds a chain of MAC lanes, the transmitter drains their sums

module morse_fir_top
#(
	parameter int NUM_LANES = 4
)
(
	input  logic clk,
	input  logic reset,
	input  logic hndshk,
	input  logic data_in,
	output logic data_out,
	output logic clk_out
);

	localparam int TAPS_PER_LANE = fir_pkg::NUM_TAPS / NUM_LANES;

	// lane_chain[j] is the sample stream entering lane j
	fir_pkg::sample_s       lane_chain   [NUM_LANES];
	fir_pkg::lane_result_s  lane_results [NUM_LANES];
	logic                   result_taken;

	serial_sample_rx serial_sample_rx_i (
		.clk        (clk),
		.reset      (reset),
		.hndshk     (hndshk),
		.data_in    (data_in),
		.new_sample (lane_chain[0])
	);

	for (genvar j = 0; j < NUM_LANES; j++)
	begin : g_lane
		if (j == NUM_LANES - 1)
		begin : g_last
			// oldest sample of the filter falls off here
			fir_lane #(
				.TAPS_PER_LANE (TAPS_PER_LANE),
				.LANE_INDEX    (j)
			) fir_lane_i (
				.clk          (clk),
				.reset        (reset),
				.hndshk       (hndshk),
				.sample_in    (lane_chain[j]),
				.shift_out    (),
				.result_taken (result_taken),
				.result       (lane_results[j])
			);
		end
		else
		begin : g_mid
			fir_lane #(
				.TAPS_PER_LANE (TAPS_PER_LANE),
				.LANE_INDEX    (j)
			) fir_lane_i (
				.clk          (clk),
				.reset        (reset),
				.hndshk       (hndshk),
				.sample_in    (lane_chain[j]),
				.shift_out    (lane_chain[j+1]),
				.result_taken (result_taken),
				.result       (lane_results[j])
			);
		end
	end

	result_tx #(
		.NUM_LANES (NUM_LANES)
	) result_tx_i (
		.clk          (clk),
		.reset        (reset),
		.lane_results (lane_results),
		.result_taken (result_taken),
		.data_out     (data_out),
		.clk_out      (clk_out)
	);

endmodule

//--- verification/clock_gen.sv
// testbench clock and reset source, 10 ns clock period
// reset is held low for 8 cycles at start and again whenever reset_req is high

module clock_gen
(
	output logic clk,
	output logic reset,
	input  logic reset_req
);

	timeunit 1ns;
	timeprecision 1ps;

	logic por_done;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// power-on reset, released on the eighth rising edge
	initial
	begin
		por_done = 1'b0;
		repeat (8) @(posedge clk);
		por_done <= 1'b1;
	end

	assign reset = por_done && !reset_req;

endmodule

//--- verification/morse_fir_tb.sv
// testbench for the serial Morse FIR filter, drives samples bit by bit
// and checks every returned 32-bit word against a software model of the filter

module morse_fir_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LANES         = 4;
	localparam int TAPS_PER_LANE     = fir_pkg::NUM_TAPS / NUM_LANES;
	localparam int RESET_CYCLES      = 8;
	localparam int RANDOM_SAMPLES    = 60;
	localparam int PRE_RESET_SAMPLES = 5;
	localparam int NUM_SAMPLES       = 32 + 64 + RANDOM_SAMPLES + PRE_RESET_SAMPLES + 1;
	localparam int CYCLES_PER_SAMPLE = fir_pkg::SAMPLE_W + TAPS_PER_LANE + 40;
	localparam longint WATCHDOG_NS   = longint'(NUM_SAMPLES) * CYCLES_PER_SAMPLE * 2 * 10;

	localparam fir_pkg::sample_t MAX_SAMPLE = 10'b01_1111_1111;
	localparam fir_pkg::sample_t MIN_SAMPLE = 10'b10_0000_0000;

	logic clk;
	logic reset;
	logic reset_req;
	logic hndshk;
	logic data_in;
	logic data_out;
	logic clk_out;

	// newest sample at index 0
	fir_pkg::sample_t history [fir_pkg::NUM_TAPS];
	fir_pkg::acc_t    exp_q [$];
	fir_pkg::acc_t    word;
	logic             clk_out_prev = 1'b0;
	int               bit_idx      = 0;
	int               toggle_count = 0;
	int               results_seen = 0;
	int               check_count  = 0;
	int               error_count  = 0;
	int               test_count   = 0;
	integer           seed         = 32'h2d60_a796;

	clock_gen clock_gen_i (
		.clk       (clk),
		.reset     (reset),
		.reset_req (reset_req)
	);

	morse_fir_top #(
		.NUM_LANES (NUM_LANES)
	) morse_fir_top_i (
		.clk      (clk),
		.reset    (reset),
		.hndshk   (hndshk),
		.data_in  (data_in),
		.data_out (data_out),
		.clk_out  (clk_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// filter model
	////////////////////////////////////////////////////////////////////////////

	function automatic void clear_history();
		for (int age = 0; age < fir_pkg::NUM_TAPS; age++)
			history[age] = '0;
	endfunction

	function automatic void push_history(input fir_pkg::sample_t value);
		for (int age = fir_pkg::NUM_TAPS - 1; age > 0; age--)
			history[age] = history[age-1];
		history[0] = value;
	endfunction

	// sum of coefficient times sample over all ages, then the scaling shift
	function automatic fir_pkg::acc_t ref_result();
		fir_pkg::acc_t sum;
		sum = '0;
		for (int age = 0; age < fir_pkg::NUM_TAPS; age++)
			sum = sum + fir_pkg::acc_t'(history[age]) * fir_pkg::acc_t'(fir_pkg::coeff_at(age));
		return sum >>> fir_pkg::SCALE_SHIFT;
	endfunction

	function automatic fir_pkg::sample_t random_sample();
		int rnd;
		rnd = $random(seed);
		return rnd[fir_pkg::SAMPLE_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		reset_req <= 1'b1;
		hndshk    <= 1'b0;
		data_in   <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_req <= 1'b0;
		@(posedge clk);
		clear_history();
	endtask

	// shift one sample in MSB first, then hold hndshk low until its word is back
	task automatic send_sample(input fir_pkg::sample_t value);
		int waited;
		int target;
		push_history(value);
		exp_q.push_back(ref_result());
		target = results_seen + 1;
		for (int b = fir_pkg::SAMPLE_W - 1; b >= 0; b--)
		begin
			@(posedge clk);
			hndshk  <= 1'b1;
			data_in <= value[b];
		end
		@(posedge clk);
		hndshk  <= 1'b0;
		data_in <= 1'b0;
		waited = 0;
		while (results_seen < target && waited < CYCLES_PER_SAMPLE)
		begin
			@(posedge clk);
			waited++;
		end
		if (results_seen < target)
		begin
			$display("no result came back within %0d cycles after sample %h",
				CYCLES_PER_SAMPLE, value);
			error_count++;
			exp_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int checks_at_start,
		input int errors_at_start);
		test_count++;
		$display("test %-10s checks %0d errors %0d", name,
			check_count - checks_at_start, error_count - errors_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// result collection and compare
	////////////////////////////////////////////////////////////////////////////

	// data_out is stable by the falling edge, a change of clk_out marks a new bit
	always @(negedge clk)
	begin : compare_results
		fir_pkg::acc_t expected;
		if (!reset)
		begin
			clk_out_prev = 1'b0;
			bit_idx      = 0;
		end
		else if (clk_out !== clk_out_prev)
		begin
			clk_out_prev  = clk_out;
			toggle_count++;
			word[bit_idx] = data_out;
			bit_idx++;
			if (bit_idx == fir_pkg::ACC_W)
			begin
				bit_idx = 0;
				check_count++;
				if (exp_q.size() == 0)
				begin
					$display("a result word arrived with no sample outstanding");
					error_count++;
				end
				else
				begin
					expected = exp_q.pop_front();
					assert (word == expected)
					else
					begin
						$display("error result expected %08h actual %08h", expected, word);
						error_count++;
					end
				end
				results_seen++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int c0;
		int e0;
		hndshk    = 1'b0;
		data_in   = 1'b0;
		reset_req = 1'b0;
		clear_history();
		wait (reset === 1'b1);
		@(posedge clk);

		// nine bits only, one short of a complete sample
		c0 = check_count;
		e0 = error_count;
		for (int b = 0; b < fir_pkg::SAMPLE_W - 1; b++)
		begin
			@(posedge clk);
			hndshk  <= 1'b1;
			data_in <= b[0];
		end
		@(posedge clk);
		hndshk  <= 1'b0;
		data_in <= 1'b0;
		repeat (CYCLES_PER_SAMPLE) @(posedge clk);
		check_count++;
		assert (toggle_count == 0 && clk_out == 1'b0)
		else
		begin
			$display("clk_out toggled %0d times although no sample was complete",
				toggle_count);
			error_count++;
		end
		apply_reset();
		report_test("idle", c0, e0);

		c0 = check_count;
		e0 = error_count;
		send_sample(MAX_SAMPLE);
		for (int i = 1; i < fir_pkg::NUM_TAPS; i++)
			send_sample('0);
		report_test("impulse", c0, e0);

		c0 = check_count;
		e0 = error_count;
		for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
			send_sample(MIN_SAMPLE);
		for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
			send_sample(MAX_SAMPLE);
		report_test("extremes", c0, e0);

		c0 = check_count;
		e0 = error_count;
		for (int i = 0; i < RANDOM_SAMPLES; i++)
			send_sample(random_sample());
		report_test("random", c0, e0);

		// delay line must come back empty after a reset
		c0 = check_count;
		e0 = error_count;
		for (int i = 0; i < PRE_RESET_SAMPLES; i++)
			send_sample(random_sample());
		apply_reset();
		send_sample(random_sample());
		report_test("reset", c0, e0);

		$display("tests %0d, results checked %0d, errors %0d",
			test_count, check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("run stopped by the watchdog after %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

//--- src.f
verilog/fir_pkg.sv
verilog/serial_sample_rx.sv
verilog/fir_lane.sv
verilog/result_tx.sv
verilog/morse_fir_top.sv
verification/clock_gen.sv
verification/morse_fir_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the Morse FIR testbench with Verilator and runs it
# the run fails when the log holds the fail message

set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module morse_fir_tb -f src.f \
	&& ./obj_dir/Vmorse_fir_tb | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; } \
	|| echo "simulation passed"
